/* Bender.yml */
package:
  name: weight_update

sources:
  - files:
      - src/wupd_pkg.sv
      - src/tap_sequencer.sv
      - src/product_line.sv
      - src/weight_divider.sv
      - src/weight_bank.sv
      - src/weight_update_top.sv
  - target: test
    files:
      - testbench/weight_update_assert.sv
      - testbench/tb_weight_update.sv

/* src/product_line.sv */
`timescale 1ns/10ps

module product_line
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                shift,
    input  wupd_pkg::tap_idx_t  tap_idx,
    input  wupd_pkg::err_t      e,
    input  wupd_pkg::ref_vec_t  ref_vec,
    output wupd_pkg::prod_t     head
);

    wupd_pkg::ref_t                         ref_sel;
    wupd_pkg::prod_t                        prod;
    wupd_pkg::prod_t [wupd_pkg::NUM_TAPS-1:0] line_q;

    assign ref_sel = ref_vec[tap_idx];

    // Both operands widened first so the multiply is signed at full width.
    assign prod = wupd_pkg::prod_t'(e) * wupd_pkg::prod_t'(ref_sel);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            line_q <= '0;
        else if (shift)
        begin
            line_q[0] <= prod;  // Newest entry.
            for (int i = 1; i < wupd_pkg::NUM_TAPS; i++)
            begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // Oldest product is tap 0 once the product phase is over.
    assign head = line_q[wupd_pkg::NUM_TAPS-1];

endmodule

/* src/tap_sequencer.sv */
`timescale 1ns/10ps

module tap_sequencer
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               start,
    input  logic               div_done,
    output wupd_pkg::tap_idx_t tap_idx,
    output logic               shift,
    output logic               div_start,
    output logic               busy,
    output logic               done
);

    wupd_pkg::seq_state_t state;
    logic                 last_tap;

    assign last_tap = (tap_idx == wupd_pkg::tap_idx_t'(wupd_pkg::NUM_TAPS - 1));

    // Products enter the line during S_MULT, then advance once per finished tap.
    assign shift     = (state == wupd_pkg::S_MULT) ||
                       ((state == wupd_pkg::S_WAIT) && div_done);
    assign div_start = (state == wupd_pkg::S_DIV);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state   <= wupd_pkg::S_IDLE;
            tap_idx <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (done)
                busy <= 1'b0;   // Busy drops together with done.

            case (state)
                wupd_pkg::S_IDLE:
                begin
                    if (start && !busy)
                    begin
                        state   <= wupd_pkg::S_MULT;
                        tap_idx <= '0;
                        busy    <= 1'b1;
                    end
                end

                wupd_pkg::S_MULT:
                begin
                    if (last_tap)
                    begin
                        tap_idx <= '0;
                        state   <= wupd_pkg::S_DIV;
                    end
                    else
                        tap_idx <= tap_idx + 1'b1;
                end

                wupd_pkg::S_DIV:
                    state <= wupd_pkg::S_WAIT;

                wupd_pkg::S_WAIT:
                begin
                    if (div_done)
                    begin
                        if (last_tap)
                        begin
                            state <= wupd_pkg::S_IDLE;
                            done  <= 1'b1;
                        end
                        else
                        begin
                            tap_idx <= tap_idx + 1'b1;
                            state   <= wupd_pkg::S_DIV;
                        end
                    end
                end

                default:
                    state <= wupd_pkg::S_IDLE;
            endcase
        end
    end

endmodule

/* src/weight_bank.sv */
`timescale 1ns/10ps

module weight_bank
(
    input  logic                  clk,
    input  logic                  rstn,
    input  wupd_pkg::tap_idx_t    tap_idx,
    input  logic                  wr_en,
    input  wupd_pkg::weight_t     wr_data,
    output wupd_pkg::weight_t     rd_data,
    output wupd_pkg::weight_vec_t weights
);

    wupd_pkg::weight_vec_t w_q;

    // Weights persist across runs and are only cleared by reset.
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            w_q <= '0;
        else if (wr_en)
            w_q[tap_idx] <= wr_data;
    end

    assign rd_data = w_q[tap_idx];  // Previous weight of the current tap.
    assign weights = w_q;

endmodule

/* src/weight_divider.sv */
`timescale 1ns/10ps

module weight_divider
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               div_start,
    input  wupd_pkg::div_req_t req,
    input  wupd_pkg::norm_t    n,
    output wupd_pkg::weight_t  result,
    output logic               div_done
);

    typedef logic [$clog2(wupd_pkg::QUOT_W+1)-1:0] step_t;

    logic                               running;
    step_t                              step;
    logic                               last_step;
    wupd_pkg::prod_t                    dividend;
    wupd_pkg::prod_t                    dividend_mag;
    wupd_pkg::norm_t                    divisor;
    logic [wupd_pkg::QUOT_W-1:0]        quo;
    logic [wupd_pkg::NORM_W-1:0]        rem;
    logic [wupd_pkg::NORM_W-1:0]        rem_sh;
    logic [wupd_pkg::NORM_W-1:0]        dvs;
    logic                               neg;
    logic                               div_ok;
    wupd_pkg::weight_t                  w_prev;
    logic signed [wupd_pkg::QUOT_W+1:0] q_ext;
    logic signed [wupd_pkg::QUOT_W+1:0] sum;
    logic                               fits;

    assign dividend     = req.prod >>> 1;
    assign dividend_mag = dividend[wupd_pkg::PROD_W-1] ? -dividend : dividend;
    assign divisor      = n >>> wupd_pkg::NORM_SHIFT;
    assign last_step    = (step == step_t'(wupd_pkg::QUOT_W));

    // Remainder shifted left with the next dividend bit.
    assign rem_sh = {rem[wupd_pkg::NORM_W-2:0], quo[wupd_pkg::QUOT_W-1]};

    always_comb
    begin
        q_ext = {2'b00, quo};
        if (neg)
            q_ext = -q_ext;     // Truncation toward zero.
        sum = q_ext + w_prev;
    end

    // Upper bits all equal means the sum fits a weight.
    assign fits = (sum[wupd_pkg::QUOT_W+1:wupd_pkg::WEIGHT_W-1] == '0) ||
                  (sum[wupd_pkg::QUOT_W+1:wupd_pkg::WEIGHT_W-1] == '1);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            running  <= 1'b0;
            step     <= '0;
            div_done <= 1'b0;
        end
        else
        begin
            div_done <= 1'b0;
            if (!running)
            begin
                if (div_start)
                begin
                    running <= 1'b1;
                    step    <= '0;
                end
            end
            else if (last_step)
            begin
                running  <= 1'b0;
                div_done <= 1'b1;
            end
            else
                step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!running && div_start)
        begin
            quo    <= dividend_mag[wupd_pkg::QUOT_W-1:0];
            rem    <= '0;
            dvs    <= divisor;
            neg    <= dividend[wupd_pkg::PROD_W-1];
            div_ok <= (divisor > 0);
            w_prev <= req.weight;
        end
        else if (running && !last_step)
        begin
            // One restoring step.
            if (rem_sh >= dvs)
            begin
                rem <= rem_sh - dvs;
                quo <= {quo[wupd_pkg::QUOT_W-2:0], 1'b1};
            end
            else
            begin
                rem <= rem_sh;
                quo <= {quo[wupd_pkg::QUOT_W-2:0], 1'b0};
            end
        end
        else if (running && last_step)
        begin
            if (!div_ok)
                result <= w_prev;   // No update without a positive divisor.
            else if (fits)
                result <= sum[wupd_pkg::WEIGHT_W-1:0];
            else if (sum[wupd_pkg::QUOT_W+1])
                result <= {1'b1, {(wupd_pkg::WEIGHT_W-1){1'b0}}};
            else
                result <= {1'b0, {(wupd_pkg::WEIGHT_W-1){1'b1}}};
        end
    end

endmodule

/* src/weight_update_top.sv */
`timescale 1ns/10ps

module weight_update_top
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start,
    input  wupd_pkg::err_t        e,
    input  wupd_pkg::ref_vec_t    ref_vec,
    input  wupd_pkg::norm_t       n,
    output wupd_pkg::weight_vec_t weights,
    output logic                  busy,
    output logic                  done
);

    wupd_pkg::tap_idx_t tap_idx;
    logic               shift;
    logic               div_start;
    logic               div_done;
    wupd_pkg::prod_t    head;
    wupd_pkg::weight_t  rd_data;
    wupd_pkg::weight_t  result;
    wupd_pkg::div_req_t req;

    assign req.prod   = head;
    assign req.weight = rd_data;

    tap_sequencer u_seq
    (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .div_done  (div_done),
        .tap_idx   (tap_idx),
        .shift     (shift),
        .div_start (div_start),
        .busy      (busy),
        .done      (done)
    );

    product_line u_prod
    (
        .clk     (clk),
        .rstn    (rstn),
        .shift   (shift),
        .tap_idx (tap_idx),
        .e       (e),
        .ref_vec (ref_vec),
        .head    (head)
    );

    weight_divider u_div
    (
        .clk       (clk),
        .rstn      (rstn),
        .div_start (div_start),
        .req       (req),
        .n         (n),
        .result    (result),
        .div_done  (div_done)
    );

    weight_bank u_bank
    (
        .clk     (clk),
        .rstn    (rstn),
        .tap_idx (tap_idx),
        .wr_en   (div_done),
        .wr_data (result),
        .rd_data (rd_data),
        .weights (weights)
    );

endmodule

/* src/wupd_pkg.sv */
package wupd_pkg;

    // Filter size and sample widths.
    localparam int NUM_TAPS   = 8;
    localparam int ERR_W      = 14;
    localparam int REF_W      = 14;
    localparam int WEIGHT_W   = 16;
    localparam int PROD_W     = 28;
    localparam int NORM_W     = 32;

    // Power estimate is scaled down before it is used as divisor.
    localparam int NORM_SHIFT = 10;

    // Magnitude bits of the halved product.
    localparam int QUOT_W     = 27;

    typedef logic signed [ERR_W-1:0]    err_t;
    typedef logic signed [REF_W-1:0]    ref_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [NORM_W-1:0]   norm_t;

    typedef logic [$clog2(NUM_TAPS)-1:0] tap_idx_t;

    typedef ref_t    [NUM_TAPS-1:0] ref_vec_t;
    typedef weight_t [NUM_TAPS-1:0] weight_vec_t;

    // One divide job.
    typedef struct packed
    {
        prod_t   prod;      // Error times reference.
        weight_t weight;    // Weight before the update.
    } div_req_t;

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_MULT,
        S_DIV,
        S_WAIT
    } seq_state_t;

endpackage

/* testbench/tb_weight_update.sv */
`timescale 1ns/10ps

module tb_weight_update;

    localparam int     CLK_PERIOD = 8;
    localparam int     NUM_RUNS   = 5;
    localparam int     RUN_CYCLES = wupd_pkg::NUM_TAPS * (wupd_pkg::QUOT_W + 6) + 20;
    localparam int     SETTLE     = 5;
    localparam int     MID_START  = 100;   // Cycle of the stray start pulse.
    localparam longint W_MAX      = (longint'(1) <<< (wupd_pkg::WEIGHT_W - 1)) - 1;
    localparam longint W_MIN      = -(longint'(1) <<< (wupd_pkg::WEIGHT_W - 1));

    logic                  clk;
    logic                  rstn;
    logic                  start;
    wupd_pkg::err_t        e;
    wupd_pkg::ref_vec_t    ref_vec;
    wupd_pkg::norm_t       n;
    wupd_pkg::weight_vec_t weights;
    logic                  busy;
    logic                  done;

    wupd_pkg::weight_vec_t exp_w;   // Expected weights.
    int                    errors;
    int                    assert_errors;

    weight_update_top i_dut
    (
        .clk     (clk),
        .rstn    (rstn),
        .start   (start),
        .e       (e),
        .ref_vec (ref_vec),
        .n       (n),
        .weights (weights),
        .busy    (busy),
        .done    (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #((NUM_RUNS * (RUN_CYCLES + SETTLE + 10) + 200) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Verification failed");
        $finish;
    end

    // Weight update rule for one tap.
    function automatic wupd_pkg::weight_t next_weight
    (
        input wupd_pkg::weight_t w_old,
        input wupd_pkg::err_t    e_s,
        input wupd_pkg::ref_t    r_s,
        input wupd_pkg::norm_t   n_s
    );
        longint num;
        longint den;
        longint sum;
        num = (longint'(e_s) * longint'(r_s)) >>> 1;
        den = longint'(n_s) >>> wupd_pkg::NORM_SHIFT;
        if (den <= 0)
            return w_old;
        sum = longint'(w_old) + num / den;   // Division truncates toward zero.
        if (sum > W_MAX)
            sum = W_MAX;
        else if (sum < W_MIN)
            sum = W_MIN;
        return wupd_pkg::weight_t'(sum);
    endfunction

    task automatic model_run
    (
        input wupd_pkg::err_t     ev,
        input wupd_pkg::ref_vec_t rv,
        input wupd_pkg::norm_t    nv
    );
        for (int i = 0; i < wupd_pkg::NUM_TAPS; i++)
        begin
            exp_w[i] = next_weight(exp_w[i], ev, rv[i], nv);
        end
    endtask

    task automatic random_inputs
    (
        output wupd_pkg::err_t     ev,
        output wupd_pkg::ref_vec_t rv,
        output wupd_pkg::norm_t    nv
    );
        ev = wupd_pkg::err_t'($urandom);
        for (int i = 0; i < wupd_pkg::NUM_TAPS; i++)
        begin
            rv[i] = wupd_pkg::ref_t'($urandom);
        end
        nv = wupd_pkg::norm_t'(1024 + ($urandom % (1 << 24)));
    endtask

    task automatic check_weights();
        for (int i = 0; i < wupd_pkg::NUM_TAPS; i++)
        begin
            assert (weights[i] == exp_w[i])
            else
            begin
                errors++;
                $display("MISMATCH time=%0t signal=weights[%0d] expected=%0d actual=%0d",
                         $time, i, exp_w[i], weights[i]);
            end
        end
    endtask

    task automatic check_idle();
        assert (busy == 1'b0)
        else
        begin
            errors++;
            $display("MISMATCH time=%0t signal=busy expected=0 actual=%0b", $time, busy);
        end
        assert (done == 1'b0)
        else
        begin
            errors++;
            $display("MISMATCH time=%0t signal=done expected=0 actual=%0b", $time, done);
        end
        check_weights();
    endtask

    // One start pulse, optionally a second one in mid-run, then wait for done.
    task automatic apply_run
    (
        input wupd_pkg::err_t     e_in,
        input wupd_pkg::ref_vec_t ref_in,
        input wupd_pkg::norm_t    n_in,
        input bit                 extra_start
    );
        int cycles;
        int dones;
        @(posedge clk);
        #1;
        e       = e_in;
        ref_vec = ref_in;
        n       = n_in;
        start   = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (busy)
        else
        begin
            errors++;
            $display("Busy did not rise the cycle after start at time %0t", $time);
        end
        cycles = 0;
        while (!done && cycles < RUN_CYCLES)
        begin
            if (extra_start && cycles == MID_START)
            begin
                start = 1'b1;
                assert (busy)
                else
                begin
                    errors++;
                    $display("Stray start pulse did not land inside a run");
                end
            end
            else
                start = 1'b0;
            @(posedge clk);
            #1;
            cycles++;
        end
        start = 1'b0;
        if (!done)
        begin
            errors++;
            $display("No done within %0d cycles of start", RUN_CYCLES);
        end
        dones = done ? 1 : 0;
        repeat (SETTLE)
        begin
            @(posedge clk);
            #1;
            if (done)
                dones++;
        end
        assert (dones == 1)
        else
        begin
            errors++;
            $display("Expected exactly one done for the run but saw %0d", dones);
        end
        assert (!busy)
        else
        begin
            errors++;
            $display("Busy still high after the run finished");
        end
        model_run(e_in, ref_in, n_in);
        check_weights();
    endtask

    initial
    begin
        wupd_pkg::err_t     ev;
        wupd_pkg::ref_vec_t rv;
        wupd_pkg::norm_t    nv;
        void'($urandom(62459));
        errors  = 0;
        exp_w   = '0;
        rstn    = 1'b0;
        start   = 1'b0;
        e       = '0;
        ref_vec = '0;
        n       = '0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        @(posedge clk);
        #1;
        check_idle();

        random_inputs(ev, rv, nv);
        apply_run(ev, rv, nv, 1'b0);

        random_inputs(ev, rv, nv);   // Accumulates onto the first run.
        apply_run(ev, rv, nv, 1'b0);

        ev = wupd_pkg::err_t'((1 << (wupd_pkg::ERR_W - 1)) - 1);
        for (int i = 0; i < wupd_pkg::NUM_TAPS; i++)
        begin
            if (i % 2 == 0)
                rv[i] = wupd_pkg::ref_t'((1 << (wupd_pkg::REF_W - 1)) - 1);
            else
                rv[i] = wupd_pkg::ref_t'(-(1 << (wupd_pkg::REF_W - 1)));
        end
        apply_run(ev, rv, wupd_pkg::norm_t'(1024), 1'b0);

        random_inputs(ev, rv, nv);
        apply_run(ev, rv, nv, 1'b1);

        random_inputs(ev, rv, nv);
        nv = wupd_pkg::norm_t'($urandom % 1024);   // Divisor becomes zero.
        apply_run(ev, rv, nv, 1'b0);

        repeat (2) @(posedge clk);
        assert_errors = i_dut.u_assert.fail_count;
        $display("Error count: %0d testbench checks, %0d concurrent assertions",
                 errors, assert_errors);
        if (errors == 0 && assert_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* testbench/weight_update_assert.sv */
`timescale 1ns/10ps

module weight_update_assert
(
    input logic                  clk,
    input logic                  rstn,
    input logic                  busy,
    input logic                  done,
    input logic                  div_start,
    input logic                  div_done,
    input logic                  div_running,
    input wupd_pkg::weight_vec_t weights
);

    int fail_count = 0;   // Read by the testbench at the end.

    done_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> (!done && !busy))
    else
    begin
        fail_count++;
        $error("done lasted more than one cycle or busy did not fall with it");
    end

    done_in_run: assert property (@(posedge clk) disable iff (!rstn)
        done |-> busy)
    else
    begin
        fail_count++;
        $error("done seen while busy was low");
    end

    weights_hold: assert property (@(posedge clk) disable iff (!rstn)
        !busy |-> $stable(weights))
    else
    begin
        fail_count++;
        $error("weights changed while idle");
    end

    no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        div_start |-> !div_running)
    else
    begin
        fail_count++;
        $error("div_start issued while a divide was running");
    end

    div_latency: assert property (@(posedge clk) disable iff (!rstn)
        div_start |-> ##(wupd_pkg::QUOT_W + 2) div_done)
    else
    begin
        fail_count++;
        $error("div_done did not follow div_start on time");
    end

endmodule

bind weight_update_top weight_update_assert u_assert
(
    .clk         (clk),
    .rstn        (rstn),
    .busy        (busy),
    .done        (done),
    .div_start   (div_start),
    .div_done    (div_done),
    .div_running (u_div.running),
    .weights     (weights)
);

/* vlog.f */
src/wupd_pkg.sv
src/tap_sequencer.sv
src/product_line.sv
src/weight_divider.sv
src/weight_bank.sv
src/weight_update_top.sv
testbench/weight_update_assert.sv
testbench/tb_weight_update.sv
